// File: all.f
hdl/opc_pkg.sv
hdl/mem_bus_if.sv
hdl/opc_core.sv
hdl/opc_memory.sv
hdl/apb_host_port.sv
hdl/opc_system.sv
verif/tb_clock_gen.sv
verif/tb_opc_system.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_opc_system \
  -f all.f -o sim_opc_system > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_opc_system > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

// File: verif/tb_opc_system.sv
`timescale 1ns/1ps

module tb_opc_system;
  import opc_pkg::*;

  localparam int clk_period = 100;
  localparam int apb_cycles = 4;
  localparam int max_polls  = 2000;
  localparam int n_tests    = 6;
  // Every test may poll up to the limit, the margin covers loading and checking.
  localparam int watchdog_ns = n_tests * max_polls * apb_cycles * clk_period + 500_000;

  logic                  clk;
  logic                  reset_b;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [apb_addr_w-1:0] paddr;
  logic [apb_data_w-1:0] pwdata;
  logic [apb_data_w-1:0] prdata;
  logic                  pready;
  logic                  pslverr;

  integer            seed;
  int                errors;
  int                test_errors;
  int                tests_failed;
  int                tests_run;
  logic [7:0]        prog [$];
  logic [data_w-1:0] model_mem [4096];
  logic [data_w-1:0] model_acc;
  logic              model_carry;
  logic [addr_w-1:0] model_pc;

  tb_clock_gen #(
    .period       (clk_period),
    .reset_cycles (16)
  ) u_clock_gen (
    .clk     (clk),
    .reset_b (reset_b)
  );

  opc_system #(
    .mem_depth (4096)
  ) DUT (
    .clk     (clk),
    .reset_b (reset_b),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED: %s is 0x%0h, expected 0x%0h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0)
      $display("Test %0d %s: passed", tests_run, name);
    else
    begin
      $display("Test %0d %s: failed with %0d errors", tests_run, name, test_errors);
      tests_failed++;
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  // One setup and one access phase, then the bus goes idle.
  task automatic apb_transfer(input logic write, input logic [apb_addr_w-1:0] addr,
                              input logic [apb_data_w-1:0] wdata,
                              output logic [apb_data_w-1:0] rdata, output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    rdata   = prdata;
    err     = pslverr;
    check_value("pready", 32'(pready), 32'h1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [apb_data_w-1:0] data,
                           output logic err);
    logic [apb_data_w-1:0] rdata;
    apb_transfer(1'b1, addr, data, rdata, err);
  endtask

  task automatic apb_read(input logic [apb_addr_w-1:0] addr, output logic [apb_data_w-1:0] data,
                          output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  task automatic reg_read(input logic [addr_w-1:0] offset, output logic [apb_data_w-1:0] data);
    logic err;
    apb_read({1'b1, offset}, data, err);
    check_value("pslverr", 32'(err), 32'h0);
  endtask

  task automatic mem_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    logic err;
    apb_write({1'b0, addr}, 32'(data), err);
    check_value("pslverr", 32'(err), 32'h0);
    model_mem[addr] = data;
  endtask

  task automatic mem_check(input logic [addr_w-1:0] addr);
    logic [apb_data_w-1:0] data;
    logic                  err;
    apb_read({1'b0, addr}, data, err);
    check_value("pslverr", 32'(err), 32'h0);
    check_value($sformatf("mem[0x%03h]", addr), data, 32'(model_mem[addr]));
  endtask

  task automatic add_instr(input opc_op_t op, input logic [addr_w-1:0] arg);
    prog.push_back({op, arg[11:8]});
    prog.push_back(arg[7:0]);
  endtask

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++)
      mem_write(12'(i), prog[i]);
    prog.delete();
  endtask

  task automatic start_program();
    logic err;
    apb_write({1'b1, reg_ctrl}, 32'h1, err);
    check_value("pslverr", 32'(err), 32'h0);
  endtask

  task automatic wait_for_halt();
    logic [apb_data_w-1:0] status;
    int                    polls;
    status = '0;
    polls  = 0;
    while (!status[stat_halted] && polls < max_polls)
    begin
      reg_read(reg_status, status);
      polls++;
    end
    if (!status[stat_halted])
    begin
      $display("Program did not halt within %0d status polls.", max_polls);
      test_errors++;
    end
  endtask

  task automatic run_to_halt();
    start_program();
    wait_for_halt();
  endtask

  // Instruction-level model. Accumulator and carry carry over between runs.
  task automatic model_run();
    logic [7:0]        b0;
    logic [7:0]        b1;
    logic [addr_w-1:0] arg;
    logic [data_w-1:0] operand;
    opc_op_t           op;
    logic              halted;
    int                steps;
    model_pc = '0;
    halted   = 1'b0;
    steps    = 0;
    while (!halted && steps < 100000)
    begin
      b0       = model_mem[model_pc];
      b1       = model_mem[model_pc + 12'd1];
      op       = opc_op_t'(b0[7:4]);
      arg      = {b0[3:0], b1};
      operand  = (op inside {op_and, op_lda, op_add, op_sub}) ? model_mem[arg] : b1;
      model_pc = model_pc + 12'd2;
      steps++;
      case (op)
        op_and, op_andi:
        begin
          model_acc   = model_acc & operand;
          model_carry = 1'b0;
        end
        op_lda, op_ldai:
          model_acc = operand;
        op_sta:
          model_mem[arg] = model_acc;
        op_add, op_addi:
          {model_carry, model_acc} = {1'b0, model_acc} + {1'b0, operand} + {8'h00, model_carry};
        op_sub, op_subi:
          {model_carry, model_acc} = {1'b0, model_acc} + {1'b0, ~operand} + {8'h00, model_carry};
        op_jpc:
          if (model_carry)
            model_pc = arg;
        op_jpz:
          if (model_acc == 8'h00)
            model_pc = arg;
        op_jp:
          model_pc = arg;
        op_not:
          model_acc = ~model_acc;
        op_sec:
          model_carry = 1'b1;
        op_halt:
          halted = 1'b1;
        default:
          ;
      endcase
    end
    if (!halted)
    begin
      $display("Model program did not reach HALT.");
      test_errors++;
    end
  endtask

  task automatic check_core_state();
    logic [apb_data_w-1:0] data;
    reg_read(reg_acc, data);
    check_value("acc", data, 32'(model_acc));
    reg_read(reg_pc, data);
    check_value("pc", data, 32'(model_pc));
    reg_read(reg_status, data);
    check_value("status", data, 32'({model_carry, 1'b1, 1'b0}));
  endtask

  task automatic memory_window();
    logic [addr_w-1:0]     addrs [16];
    logic [apb_data_w-1:0] data;
    reg_read(reg_status, data);
    check_value("status", data, 32'h0);
    for (int i = 0; i < 16; i++)
    begin
      addrs[i] = 12'($random(seed));
      mem_write(addrs[i], 8'($random(seed)));
    end
    for (int i = 0; i < 16; i++)
      mem_check(addrs[i]);
    finish_test("memory window");
  endtask

  task automatic arithmetic_ops();
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] c;
    for (int i = 0; i < 4; i++)
    begin
      a = 8'($random(seed));
      b = 8'($random(seed));
      c = 8'($random(seed));
      add_instr(op_andi, 12'h000);
      add_instr(op_ldai, {4'h0, a});
      add_instr(op_addi, {4'h0, b});
      add_instr(op_sta, 12'h900);
      add_instr(op_andi, {4'h0, c});
      add_instr(op_sta, 12'h901);
      add_instr(op_not, 12'h000);
      add_instr(op_sta, 12'h902);
      add_instr(op_sec, 12'h000);
      add_instr(op_subi, {4'h0, b});
      add_instr(op_sta, 12'h903);
      add_instr(op_ldai, {4'h0, c});
      add_instr(op_sub, 12'h900);
      add_instr(op_halt, 12'h000);
      load_program();
      run_to_halt();
      model_run();
      check_core_state();
      for (int j = 0; j < 4; j++)
        mem_check(12'h900 + 12'(j));
    end
    finish_test("arithmetic and logic");
  endtask

  task automatic memory_operands();
    for (int i = 0; i < 3; i++)
    begin
      mem_write(12'hA00, 8'($random(seed)));
      mem_write(12'hA01, 8'($random(seed)));
      mem_write(12'hA02, 8'($random(seed)));
      add_instr(op_lda, 12'hA00);
      add_instr(op_add, 12'hA01);
      add_instr(op_sta, 12'hA10);
      add_instr(op_and, 12'hA02);
      add_instr(op_sta, 12'hA11);
      add_instr(op_add, 12'hA10);
      add_instr(op_sta, 12'hA12);
      add_instr(op_halt, 12'h000);
      load_program();
      run_to_halt();
      model_run();
      check_core_state();
      for (int j = 0; j < 3; j++)
        mem_check(12'hA10 + 12'(j));
    end
    finish_test("memory operands and store");
  endtask

  task automatic branching();
    logic [data_w-1:0]     count;
    logic [apb_data_w-1:0] data;
    count = (8'($random(seed)) & 8'h07) + 8'd2;
    mem_write(12'hB00, 8'h00);
    add_instr(op_ldai, {4'h0, count});
    add_instr(op_sec, 12'h000);
    add_instr(op_subi, 12'h001);
    add_instr(op_jpz, 12'h00A);
    add_instr(op_jp, 12'h004);
    // Leaves carry set, so the overflowing ADDI also takes the JPC.
    add_instr(op_ldai, 12'h0F0);
    add_instr(op_addi, 12'h020);
    add_instr(op_jpc, 12'h014);
    add_instr(op_ldai, 12'h000);
    add_instr(op_halt, 12'h000);
    add_instr(op_ldai, 12'h05A);
    add_instr(op_sta, 12'hB00);
    add_instr(op_jp, 12'h01C);
    add_instr(op_halt, 12'h000);
    add_instr(op_halt, 12'h000);
    load_program();
    run_to_halt();
    model_run();
    check_core_state();
    mem_check(12'hB00);
    reg_read(reg_pc, data);
    check_value("pc after HALT", data, 32'h01E);
    finish_test("branches");
  endtask

  // Countdown loop whose SEC sits at base. From 255 it keeps the core busy for over 2000 cycles.
  task automatic countdown_program(input logic [data_w-1:0] count, input logic [addr_w-1:0] base);
    add_instr(op_ldai, {4'h0, count});
    add_instr(op_sec, 12'h000);
    add_instr(op_subi, 12'h001);
    add_instr(op_jpz, base + 12'h008);
    add_instr(op_jp, base + 12'h002);
  endtask

  task automatic access_protection();
    logic [data_w-1:0]     value;
    logic [apb_data_w-1:0] data;
    logic                  err;
    value = 8'($random(seed));
    mem_write(12'hC00, value);
    countdown_program(8'hFF, 12'h002);
    add_instr(op_halt, 12'h000);
    load_program();
    start_program();
    apb_write({1'b0, 12'hC00}, 32'(~value), err);
    check_value("pslverr on busy write", 32'(err), 32'h1);
    apb_read({1'b0, 12'hC00}, data, err);
    check_value("pslverr on busy read", 32'(err), 32'h1);
    check_value("prdata on busy read", data, 32'h0);
    reg_read(reg_status, data);
    check_value("status busy", 32'(data[stat_busy]), 32'h1);
    wait_for_halt();
    model_run();
    mem_check(12'hC00);
    check_core_state();
    apb_write({1'b1, reg_status}, 32'hFFFF_FFFF, err);
    check_value("pslverr", 32'(err), 32'h0);
    apb_write({1'b1, reg_acc}, 32'h0000_00A5, err);
    check_value("pslverr", 32'(err), 32'h0);
    apb_write({1'b1, reg_pc}, 32'h0000_0123, err);
    check_value("pslverr", 32'(err), 32'h0);
    check_core_state();
    finish_test("protection");
  endtask

  task automatic restart_after_halt();
    logic [apb_data_w-1:0] data;
    mem_write(12'hD00, 8'($random(seed)));
    add_instr(op_andi, 12'h000);
    add_instr(op_ldai, {4'h0, 8'($random(seed))});
    add_instr(op_add, 12'hD00);
    add_instr(op_sta, 12'hD01);
    countdown_program(8'h40, 12'h00A);
    add_instr(op_lda, 12'hD01);
    add_instr(op_halt, 12'h000);
    load_program();
    run_to_halt();
    model_run();
    check_core_state();
    mem_check(12'hD01);
    start_program();
    reg_read(reg_status, data);
    check_value("status halted and busy", 32'({data[stat_halted], data[stat_busy]}), 32'h1);
    wait_for_halt();
    model_run();
    check_core_state();
    mem_check(12'hD01);
    finish_test("restart");
  endtask

  initial
  begin
    seed         = 32'h5f7dfbc0;
    errors       = 0;
    test_errors  = 0;
    tests_failed = 0;
    tests_run    = 0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    model_acc    = '0;
    model_carry  = 1'b0;
    model_pc     = '0;
    wait (reset_b === 1'b1);
    memory_window();
    arithmetic_ops();
    memory_operands();
    branching();
    access_protection();
    restart_after_halt();
    $display("Summary: %0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns before the tests completed.", watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int period       = 100,
  parameter int reset_cycles = 16
) (
  output logic clk,
  output logic reset_b
);

  initial
  begin
    clk = 1'b0;
    forever
      #(period / 2) clk = ~clk;
  end

  // Reset is released just after a rising edge, like every other input.
  initial
  begin
    reset_b = 1'b0;
    repeat (reset_cycles)
      @(posedge clk);
    #1;
    reset_b = 1'b1;
  end

endmodule

// File: hdl/opc_system.sv
`timescale 1ns/1ps

module opc_system #(
  parameter int mem_depth = 4096
) (
  input  logic                           clk,
  input  logic                           reset_b,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [opc_pkg::apb_addr_w-1:0] paddr,
  input  logic [opc_pkg::apb_data_w-1:0] pwdata,
  output logic [opc_pkg::apb_data_w-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr
);
  import opc_pkg::*;

  logic              start;
  logic              busy;
  logic              halted;
  logic              carry;
  logic [data_w-1:0] acc;
  logic [addr_w-1:0] pc;

  mem_bus_if cpu_bus ();
  mem_bus_if host_bus ();

  apb_host_port u_host_port (
    .clk     (clk),
    .reset_b (reset_b),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .hbus    (host_bus.core),
    .start   (start),
    .busy    (busy),
    .halted  (halted),
    .carry   (carry),
    .acc     (acc),
    .pc      (pc)
  );

  opc_core u_core (
    .clk     (clk),
    .reset_b (reset_b),
    .start   (start),
    .mbus    (cpu_bus.core),
    .busy    (busy),
    .halted  (halted),
    .carry   (carry),
    .acc     (acc),
    .pc      (pc)
  );

  opc_memory #(
    .depth (mem_depth)
  ) u_memory (
    .clk  (clk),
    .cpu  (cpu_bus.mem),
    .host (host_bus.mem)
  );

endmodule

// File: hdl/apb_host_port.sv
`timescale 1ns/1ps

module apb_host_port (
  input  logic                           clk,
  input  logic                           reset_b,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [opc_pkg::apb_addr_w-1:0] paddr,
  input  logic [opc_pkg::apb_data_w-1:0] pwdata,
  output logic [opc_pkg::apb_data_w-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr,
  mem_bus_if.core                        hbus,
  output logic                           start,
  input  logic                           busy,
  input  logic                           halted,
  input  logic                           carry,
  input  logic [opc_pkg::data_w-1:0]     acc,
  input  logic [opc_pkg::addr_w-1:0]     pc
);
  import opc_pkg::*;

  logic                  setup;
  logic                  access;
  logic                  wr_access;
  logic                  mem_sel;
  logic [addr_w-1:0]     offset;
  logic [apb_data_w-1:0] rd_data;

  assign setup     = psel && !penable;
  assign access    = psel && penable;
  assign wr_access = access && pwrite;
  assign mem_sel   = !paddr[apb_addr_w-1];
  assign offset    = paddr[addr_w-1:0];

  assign pready = 1'b1;

  // The error captured in setup also blocks the write in the access phase.
  assign hbus.addr  = offset;
  assign hbus.wdata = pwdata[data_w-1:0];
  assign hbus.we    = wr_access && mem_sel && !pslverr;

  // Start is taken on the same edge that commits the control write.
  assign start = wr_access && !mem_sel && offset == reg_ctrl && pwdata[0] && !busy;

  always_comb
  begin
    rd_data = '0;
    if (mem_sel)
    begin
      if (!busy)
        rd_data[data_w-1:0] = hbus.rdata;
    end
    else
    begin
      case (offset)
        reg_status:
        begin
          rd_data[stat_busy]   = busy;
          rd_data[stat_halted] = halted;
          rd_data[stat_carry]  = carry;
        end
        reg_acc:
          rd_data[data_w-1:0] = acc;
        reg_pc:
          rd_data[addr_w-1:0] = pc;
        default:
          rd_data = '0;
      endcase
    end
  end

  // Read data and error are sampled at the end of setup for the access phase.
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end
    else if (setup)
    begin
      prdata  <= pwrite ? '0 : rd_data;
      pslverr <= mem_sel && busy;
    end
    else if (!access)
      pslverr <= 1'b0;
  end

  // Every access phase comes straight after its setup phase.
  a_access_after_setup: assert property (
    @(posedge clk) disable iff (!reset_b)
    penable |-> psel && $past(psel && !penable)
  ) else $error("APB penable without a preceding setup phase.");

endmodule

// File: hdl/opc_memory.sv
`timescale 1ns/1ps

module opc_memory #(
  parameter int depth = 4096
) (
  input  logic    clk,
  mem_bus_if.mem  cpu,
  mem_bus_if.mem  host
);
  import opc_pkg::*;

  localparam int aw = $clog2(depth);

  logic [data_w-1:0] mem [depth];
  logic [aw-1:0]     cpu_idx;
  logic [aw-1:0]     host_idx;

  // A smaller memory aliases into the 12-bit address space.
  assign cpu_idx  = cpu.addr[aw-1:0];
  assign host_idx = host.addr[aw-1:0];

  assign cpu.rdata  = mem[cpu_idx];
  assign host.rdata = mem[host_idx];

  // The processor write comes last so it wins on a shared address.
  always_ff @(posedge clk)
  begin
    if (host.we)
      mem[host_idx] <= host.wdata;
    if (cpu.we)
      mem[cpu_idx] <= cpu.wdata;
  end

  // The host port refuses memory writes while the core runs.
  a_no_dual_write: assert property (
    @(posedge clk)
    cpu.we |-> !host.we
  ) else $error("Host and processor wrote memory in the same cycle.");

endmodule

// File: hdl/opc_core.sv
`timescale 1ns/1ps

module opc_core (
  input  logic                       clk,
  input  logic                       reset_b,
  input  logic                       start,
  mem_bus_if.core                    mbus,
  output logic                       busy,
  output logic                       halted,
  output logic                       carry,
  output logic [opc_pkg::data_w-1:0] acc,
  output logic [opc_pkg::addr_w-1:0] pc
);
  import opc_pkg::*;

  opc_state_t        state_q;
  opc_op_t           op_q;
  logic [addr_w-1:0] opnd_q;
  logic [addr_w-1:0] pc_q;
  logic [data_w-1:0] acc_q;
  logic              carry_q;
  logic              busy_q;
  logic              halted_q;
  logic              store;
  logic              subtract;
  logic [data_w-1:0] addend;
  logic [data_w:0]   sum;

  // Operations that fetch their operand from memory through rdmem.
  function automatic logic is_direct(opc_op_t op);
    return op inside {op_and, op_lda, op_add, op_sub};
  endfunction

  assign store     = busy_q && state_q == exec && op_q == op_sta;
  assign mbus.addr = (store || state_q == rdmem) ? opnd_q : pc_q;
  assign mbus.wdata = acc_q;
  assign mbus.we   = store;

  // Subtraction adds the inverted operand, carry in is the no-borrow flag.
  assign subtract = op_q == op_sub || op_q == op_subi;
  assign addend   = subtract ? ~opnd_q[data_w-1:0] : opnd_q[data_w-1:0];
  assign sum      = {1'b0, acc_q} + {1'b0, addend} + {{data_w{1'b0}}, carry_q};

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      state_q  <= fetch0;
      pc_q     <= '0;
      acc_q    <= '0;
      carry_q  <= 1'b0;
      busy_q   <= 1'b0;
      halted_q <= 1'b0;
    end
    else if (!busy_q)
    begin
      if (start)
      begin
        state_q  <= fetch0;
        pc_q     <= '0;
        halted_q <= 1'b0;
        busy_q   <= 1'b1;
      end
    end
    else
    begin
      case (state_q)
        fetch0:
        begin
          state_q <= fetch1;
          pc_q    <= pc_q + 12'd1;
        end
        fetch1:
        begin
          state_q <= is_direct(op_q) ? rdmem : exec;
          pc_q    <= pc_q + 12'd1;
        end
        rdmem:
          state_q <= exec;
        exec:
        begin
          state_q <= fetch0;
          case (op_q)
            op_and, op_andi:
            begin
              acc_q   <= acc_q & opnd_q[data_w-1:0];
              carry_q <= 1'b0;
            end
            op_lda, op_ldai:
              acc_q <= opnd_q[data_w-1:0];
            op_add, op_addi, op_sub, op_subi:
              {carry_q, acc_q} <= sum;
            op_not:
              acc_q <= ~acc_q;
            op_sec:
              carry_q <= 1'b1;
            op_jpc:
              if (carry_q)
                pc_q <= opnd_q;
            op_jpz:
              if (acc_q == '0)
                pc_q <= opnd_q;
            op_jp:
              pc_q <= opnd_q;
            op_halt:
            begin
              busy_q   <= 1'b0;
              halted_q <= 1'b1;
            end
            // STA is handled by the memory port, E does nothing.
            default:
              ;
          endcase
        end
        default:
          state_q <= fetch0;
      endcase
    end
  end

  // The low operand byte is an immediate, an address byte, or the byte read in rdmem.
  always_ff @(posedge clk)
  begin
    if (busy_q && state_q == fetch0)
    begin
      op_q                    <= opc_op_t'(mbus.rdata[7:4]);
      opnd_q[addr_w-1:data_w] <= mbus.rdata[3:0];
    end
    if (busy_q && (state_q == fetch1 || state_q == rdmem))
      opnd_q[data_w-1:0] <= mbus.rdata;
  end

  assign busy   = busy_q;
  assign halted = halted_q;
  assign carry  = carry_q;
  assign acc    = acc_q;
  assign pc     = pc_q;

  // A write comes two cycles after its STA opcode was fetched, which places it in exec.
  a_store_after_fetch: assert property (
    @(posedge clk) disable iff (!reset_b)
    mbus.we |-> $past(state_q, 2) == fetch0 && $past(mbus.rdata[7:4], 2) == op_sta
  ) else $error("Memory write outside the STA execute cycle.");

  // The host port only forms a start pulse while the core is idle.
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (!reset_b)
    start |-> !busy_q
  ) else $error("Start pulse received while the core is busy.");

endmodule

// File: hdl/mem_bus_if.sv
`timescale 1ns/1ps

// One memory access port: combinational read, write on the rising edge.
interface mem_bus_if;
  import opc_pkg::*;

  logic [addr_w-1:0] addr;
  logic [data_w-1:0] wdata;
  logic [data_w-1:0] rdata;
  logic              we;

  modport core (
    output addr,
    output wdata,
    output we,
    input  rdata
  );

  modport mem (
    input  addr,
    input  wdata,
    input  we,
    output rdata
  );

endinterface

// File: hdl/opc_pkg.sv
package opc_pkg;

  localparam int addr_w     = 12;
  localparam int data_w     = 8;
  localparam int apb_addr_w = 13;
  localparam int apb_data_w = 32;

  // Fetch and execute sequence of the processor.
  typedef enum logic [1:0] {
    fetch0 = 2'b00,
    fetch1 = 2'b01,
    rdmem  = 2'b10,
    exec   = 2'b11
  } opc_state_t;

  // Upper nibble of the first instruction byte.
  typedef enum logic [3:0] {
    op_and  = 4'h0,
    op_lda  = 4'h1,
    op_sta  = 4'h2,
    op_add  = 4'h3,
    op_sub  = 4'h4,
    op_jpc  = 4'h5,
    op_jpz  = 4'h6,
    op_jp   = 4'h7,
    op_andi = 4'h8,
    op_ldai = 4'h9,
    op_not  = 4'hA,
    op_addi = 4'hB,
    op_subi = 4'hC,
    op_sec  = 4'hD,
    op_nop  = 4'hE,
    op_halt = 4'hF
  } opc_op_t;

  // Register byte offsets, valid when APB address bit 12 is set.
  localparam logic [addr_w-1:0] reg_ctrl   = 12'h000;
  localparam logic [addr_w-1:0] reg_status = 12'h004;
  localparam logic [addr_w-1:0] reg_acc    = 12'h008;
  localparam logic [addr_w-1:0] reg_pc     = 12'h00C;

  // Status register bit positions.
  localparam int stat_busy   = 0;
  localparam int stat_halted = 1;
  localparam int stat_carry  = 2;

endpackage
